/* CacheTypes.sv */
/*
 Shared enums of the data cache.
 CacheCommand is what the controller asks of the replacer,
 CacheOp is the request opcode seen on the core side.
*/
`default_nettype none

package CacheTypes;

    // Replacer commands
    typedef enum logic [1:0] {
        CacheCommand_WriteThrough = 2'd0,
        CacheCommand_Replace      = 2'd1,
        CacheCommand_Invalidate   = 2'd2
    } CacheCommand;

    // Core request opcodes
    typedef enum logic [1:0] {
        CacheOp_Load  = 2'd0,
        CacheOp_Store = 2'd1,
        CacheOp_Flush = 2'd2
    } CacheOp;

endpackage

`default_nettype wire

/* DCacheArray.sv */
/*
 Storage of the cache: one valid bit, tag and line per index.
 Reads follow the index combinationally, writes land at the clock edge.
 Valid bits clear on reset, tags and lines keep whatever they hold.
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module DCacheArray (
    input  logic clk,
    input  logic rst,
    input  logic writeEnable,
    input  logic [`CACHE_INDEX_WIDTH-1:0] index,
    input  logic writeValid,
    input  logic [`CACHE_TAG_WIDTH-1:0] writeTag,
    input  logic [`CACHE_LINE_WIDTH-1:0] writeData,
    output logic readValid,
    output logic [`CACHE_TAG_WIDTH-1:0] readTag,
    output logic [`CACHE_LINE_WIDTH-1:0] readData
);
    localparam int LineCount = 1 << `CACHE_INDEX_WIDTH;

    logic [LineCount-1:0] validBits;
    logic [`CACHE_TAG_WIDTH-1:0] tags [LineCount];
    logic [`CACHE_LINE_WIDTH-1:0] lines [LineCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (writeEnable) begin
            validBits[index] <= writeValid;
        end
    end

    // Tag and data follow every write, even an invalidating one
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            tags[index] <= writeTag;
            lines[index] <= writeData;
        end
    end

    assign readValid = validBits[index];
    assign readTag = tags[index];
    assign readData = lines[index];

endmodule

`default_nettype wire

/* DCacheChecker.sv */
/*
 Protocol assertions for the data cache, bound into DCacheTop.
 Covers the memory enable and done handshake and the response pulse.
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module DCacheChecker (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic respDone,
    input logic [`CACHE_MEM_ADDR_WIDTH-1:0] memAddr,
    input logic memReadEnable,
    input logic memWriteEnable,
    input logic memReadDone,
    input logic memWriteDone
);
    // One memory operation at a time
    exclusiveEnables: assert property (@(posedge clk) disable iff (rst)
        !(memReadEnable && memWriteEnable))
        else $error("memReadEnable and memWriteEnable high together");

    // Read request held with a stable address until its done pulse
    readHeld: assert property (@(posedge clk) disable iff (rst)
        (memReadEnable && !memReadDone) |=> (memReadEnable && $stable(memAddr)))
        else $error("memReadEnable or memAddr changed before memReadDone");

    writeHeld: assert property (@(posedge clk) disable iff (rst)
        (memWriteEnable && !memWriteDone) |=> (memWriteEnable && $stable(memAddr)))
        else $error("memWriteEnable or memAddr changed before memWriteDone");

    respInsideBusy: assert property (@(posedge clk) disable iff (rst)
        respDone |-> busy)
        else $error("respDone seen while busy is low");

endmodule

bind DCacheTop DCacheChecker DCacheChecker_inst (
    .clk(clk), .rst(rst), .busy(busy), .respDone(respDone), .memAddr(memAddr),
    .memReadEnable(memReadEnable), .memWriteEnable(memWriteEnable),
    .memReadDone(memReadDone), .memWriteDone(memWriteDone)
);

`default_nettype wire

/* DCacheController.sv */
/*
 Request side of the cache. Accepts one core request while not busy,
 checks for a hit, merges store words and runs replacer commands in order.
 Ends every request with a one-cycle respDone, load data comes with it.
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module DCacheController (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    input  CacheTypes::CacheOp reqOp,
    input  logic [`CACHE_ADDR_WIDTH-1:0] reqAddr,
    input  logic [`CACHE_WORD_WIDTH-1:0] reqData,
    output logic busy,
    output logic respDone,
    output logic [`CACHE_WORD_WIDTH-1:0] respData,

    output logic replacerEnable,
    output CacheTypes::CacheCommand replacerCommand,
    output logic [`CACHE_MEM_ADDR_WIDTH-1:0] replacerAddr,
    input  logic replacerDone,

    input  logic rplWriteEnable,
    input  logic [`CACHE_INDEX_WIDTH-1:0] rplIndex,
    input  logic rplWriteValid,
    input  logic [`CACHE_TAG_WIDTH-1:0] rplWriteTag,
    input  logic [`CACHE_LINE_WIDTH-1:0] rplWriteData,

    output logic arrayWriteEnable,
    output logic [`CACHE_INDEX_WIDTH-1:0] arrayIndex,
    output logic arrayWriteValid,
    output logic [`CACHE_TAG_WIDTH-1:0] arrayWriteTag,
    output logic [`CACHE_LINE_WIDTH-1:0] arrayWriteData,
    input  logic arrayReadValid,
    input  logic [`CACHE_TAG_WIDTH-1:0] arrayReadTag,
    input  logic [`CACHE_LINE_WIDTH-1:0] arrayReadData
);
    import CacheTypes::*;

    typedef enum logic [2:0] {
        StateIdle, StateLookup, StateIssue, StateWaitReplacer, StateMerge, StateRespond
    } State;

    State state;
    State nextState;
    CacheCommand cmdReg;
    CacheCommand nextCmd;

    // Accepted request
    CacheOp opReg;
    logic [`CACHE_ADDR_WIDTH-1:0] addrReg;
    logic [`CACHE_WORD_WIDTH-1:0] dataReg;

    logic [`CACHE_OFFSET_WIDTH-1:0] addrOffset;
    logic [`CACHE_INDEX_WIDTH-1:0] addrIndex;
    logic [`CACHE_TAG_WIDTH-1:0] addrTag;
    logic hit;
    logic replacerActive;
    logic [`CACHE_LINE_WIDTH-1:0] mergedLine;

    assign addrOffset = addrReg[`CACHE_OFFSET_WIDTH-1:0];
    assign addrIndex = addrReg[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
    assign addrTag = addrReg[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
    assign hit = arrayReadValid && (arrayReadTag == addrTag);

    assign busy = (state != StateIdle);
    assign respDone = (state == StateRespond);
    assign respData = arrayReadData[addrOffset * `CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH];

    assign replacerEnable = (state == StateIssue);
    assign replacerCommand = cmdReg;
    assign replacerAddr = addrReg[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_WIDTH];

    // Store word dropped into the current line
    always_comb begin
        mergedLine = arrayReadData;
        mergedLine[addrOffset * `CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH] = dataReg;
    end

    // Replacer owns the array while its command runs
    assign replacerActive = (state == StateIssue) || (state == StateWaitReplacer);

    always_comb begin
        if (replacerActive) begin
            arrayWriteEnable = rplWriteEnable;
            arrayIndex = rplIndex;
            arrayWriteValid = rplWriteValid;
            arrayWriteTag = rplWriteTag;
            arrayWriteData = rplWriteData;
        end else begin
            arrayWriteEnable = (state == StateMerge);
            arrayIndex = addrIndex;
            arrayWriteValid = 1'b1;
            arrayWriteTag = addrTag;
            arrayWriteData = mergedLine;
        end
    end

    always_comb begin
        nextState = state;
        nextCmd = cmdReg;
        case (state)
            StateIdle: begin
                if (reqValid) begin
                    nextState = StateLookup;
                end
            end
            StateLookup: begin
                case (opReg)
                    CacheOp_Load,
                    CacheOp_Store: begin
                        if (!hit) begin
                            nextState = StateIssue;
                            nextCmd = CacheCommand_Replace;
                        end else if (opReg == CacheOp_Store) begin
                            nextState = StateMerge;
                        end else begin
                            nextState = StateRespond;
                        end
                    end
                    CacheOp_Flush: begin
                        nextState = StateIssue;
                        nextCmd = CacheCommand_Invalidate;
                    end
                    default: nextState = StateRespond;
                endcase
            end
            StateIssue: nextState = StateWaitReplacer;
            StateWaitReplacer: begin
                // A refill for a store still has to merge and write through
                if (replacerDone) begin
                    if ((cmdReg == CacheCommand_Replace) && (opReg == CacheOp_Store)) begin
                        nextState = StateMerge;
                    end else begin
                        nextState = StateRespond;
                    end
                end
            end
            StateMerge: begin
                nextState = StateIssue;
                nextCmd = CacheCommand_WriteThrough;
            end
            StateRespond: nextState = StateIdle;
            default: nextState = StateIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
            cmdReg <= CacheCommand_WriteThrough;
        end else begin
            state <= nextState;
            cmdReg <= nextCmd;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == StateIdle) && reqValid) begin
            opReg <= reqOp;
            addrReg <= reqAddr;
            dataReg <= reqData;
        end
    end

endmodule

`default_nettype wire

/* DCacheReplacer.sv */
/*
 Line mover between the cache array and external memory.
 A one-cycle enable starts a command on commandAddr, done pulses once at its end.
 WriteThrough copies the array line to memory, Replace refills it from memory,
 Invalidate clears the indexed line.
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module DCacheReplacer (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  CacheTypes::CacheCommand command,
    input  logic [`CACHE_MEM_ADDR_WIDTH-1:0] commandAddr,
    output logic done,

    output logic arrayWriteEnable,
    output logic [`CACHE_INDEX_WIDTH-1:0] arrayIndex,
    output logic arrayWriteValid,
    output logic [`CACHE_TAG_WIDTH-1:0] arrayWriteTag,
    output logic [`CACHE_LINE_WIDTH-1:0] arrayWriteData,
    input  logic [`CACHE_LINE_WIDTH-1:0] arrayReadData,

    output logic [`CACHE_MEM_ADDR_WIDTH-1:0] memAddr,
    output logic memReadEnable,
    output logic memWriteEnable,
    output logic [`CACHE_LINE_WIDTH-1:0] memWriteValue,
    input  logic memReadDone,
    input  logic memWriteDone,
    input  logic [`CACHE_LINE_WIDTH-1:0] memReadValue
);
    import CacheTypes::*;

    typedef enum logic [2:0] {
        StateNone                 = 3'h0,
        StateReadCache            = 3'h1,
        StateWriteMemory          = 3'h2,
        StateInvalidateForReplace = 3'h3,
        StateReadMemory           = 3'h4,
        StateWriteCache           = 3'h5,
        StateInvalidate           = 3'h6
    } State;

    State state;
    State nextState;
    logic [`CACHE_LINE_WIDTH-1:0] lineReg;

    // The array request always targets the command's line
    assign arrayIndex = commandAddr[`CACHE_INDEX_WIDTH-1:0];
    assign arrayWriteTag = commandAddr[`CACHE_MEM_ADDR_WIDTH-1:`CACHE_INDEX_WIDTH];
    assign arrayWriteEnable = (state == StateInvalidate)
                           || (state == StateInvalidateForReplace)
                           || (state == StateWriteCache);
    // Only the refill leaves the line valid
    assign arrayWriteValid = (state == StateWriteCache);
    assign arrayWriteData = lineReg;

    assign memAddr = commandAddr;
    assign memReadEnable = (state == StateReadMemory);
    assign memWriteEnable = (state == StateWriteMemory);
    assign memWriteValue = lineReg;

    assign done = ((state == StateWriteMemory) && memWriteDone)
               || (state == StateWriteCache)
               || (state == StateInvalidate);

    always_comb begin
        nextState = state;
        case (state)
            StateNone: begin
                if (enable) begin
                    case (command)
                        CacheCommand_WriteThrough: nextState = StateReadCache;
                        CacheCommand_Replace:      nextState = StateInvalidateForReplace;
                        CacheCommand_Invalidate:   nextState = StateInvalidate;
                        default:                   nextState = StateNone;
                    endcase
                end
            end
            StateReadCache: nextState = StateWriteMemory;
            StateWriteMemory: begin
                if (memWriteDone) begin
                    nextState = StateNone;
                end
            end
            StateInvalidateForReplace: nextState = StateReadMemory;
            StateReadMemory: begin
                if (memReadDone) begin
                    nextState = StateWriteCache;
                end
            end
            StateWriteCache: nextState = StateNone;
            StateInvalidate: nextState = StateNone;
            default: nextState = StateNone;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateNone;
        end else begin
            state <= nextState;
        end
    end

    // Line buffer for both directions
    always_ff @(posedge clk) begin
        if (state == StateReadCache) begin
            lineReg <= arrayReadData;
        end else if ((state == StateReadMemory) && memReadDone) begin
            lineReg <= memReadValue;
        end
    end

endmodule

`default_nettype wire

/* DCacheTb.sv */
/*
 Testbench of the data cache. Sends random loads, stores and flushes from a
 small address pool, answers memory with random latency and checks every
 response against a reference cache model kept here.
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module DCacheTb;
    import CacheTypes::*;

    localparam int RequestCount = 400;
    localparam int CycleLimit = RequestCount * 40;
    localparam int MemLineCount = 1 << `CACHE_MEM_ADDR_WIDTH;
    localparam int LineCount = 1 << `CACHE_INDEX_WIDTH;
    localparam int DelayCount = 256;

    logic clk;
    logic rst;
    logic reqValid;
    CacheOp reqOp;
    logic [`CACHE_ADDR_WIDTH-1:0] reqAddr;
    logic [`CACHE_WORD_WIDTH-1:0] reqData;
    logic busy;
    logic respDone;
    logic [`CACHE_WORD_WIDTH-1:0] respData;
    logic [`CACHE_MEM_ADDR_WIDTH-1:0] memAddr;
    logic memReadEnable;
    logic memWriteEnable;
    logic [`CACHE_LINE_WIDTH-1:0] memWriteValue;
    logic memReadDone = 1'b0;
    logic memWriteDone = 1'b0;
    logic [`CACHE_LINE_WIDTH-1:0] memReadValue = '0;

    // Memory model state
    logic [`CACHE_LINE_WIDTH-1:0] memLines [MemLineCount];
    int delays [DelayCount];
    int delayIndex;
    int memDelay;
    logic memActive;
    int memReadCount;
    int memWriteCount;
    logic [`CACHE_MEM_ADDR_WIDTH-1:0] lastReadAddr;
    logic [`CACHE_MEM_ADDR_WIDTH-1:0] lastWriteAddr;
    logic [`CACHE_LINE_WIDTH-1:0] lastWriteLine;

    // Reference cache
    logic refValid [LineCount];
    logic [`CACHE_TAG_WIDTH-1:0] refTag [LineCount];
    logic [`CACHE_LINE_WIDTH-1:0] refLine [LineCount];

    int dataErrors = 0;
    int memErrors = 0;
    int protocolErrors = 0;
    int cycleCount = 0;
    int i;
    int n;
    int pick;
    CacheOp op;
    logic [`CACHE_ADDR_WIDTH-1:0] addr;

    DCacheTop DCacheTop_inst (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr), .reqData(reqData),
        .busy(busy), .respDone(respDone), .respData(respData),
        .memAddr(memAddr), .memReadEnable(memReadEnable), .memWriteEnable(memWriteEnable),
        .memWriteValue(memWriteValue), .memReadDone(memReadDone),
        .memWriteDone(memWriteDone), .memReadValue(memReadValue)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Every word differs by its full line address and word position
    function automatic logic [`CACHE_LINE_WIDTH-1:0] fillLine(input int a);
        logic [`CACHE_LINE_WIDTH-1:0] line;
        for (int w = 0; w < (1 << `CACHE_OFFSET_WIDTH); w++) begin
            line[w * `CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH] =
                {6'h2b, 10'(a), 14'(a * 13 + 7), 2'(w)};
        end
        return line;
    endfunction

    // Memory answers one enable at a time after a drawn delay
    always @(posedge clk) begin
        memReadDone <= 1'b0;
        memWriteDone <= 1'b0;
        if (rst) begin
            for (int a = 0; a < MemLineCount; a++) begin
                memLines[a] = fillLine(a);
            end
            memActive <= 1'b0;
            delayIndex <= 0;
            memReadCount <= 0;
            memWriteCount <= 0;
        end else if (memActive) begin
            if (memDelay <= 1) begin
                memActive <= 1'b0;
                if (memReadEnable) begin
                    memReadValue <= memLines[memAddr];
                    memReadDone <= 1'b1;
                    memReadCount <= memReadCount + 1;
                    lastReadAddr <= memAddr;
                end else if (memWriteEnable) begin
                    memLines[memAddr] = memWriteValue;
                    memWriteDone <= 1'b1;
                    memWriteCount <= memWriteCount + 1;
                    lastWriteAddr <= memAddr;
                    lastWriteLine <= memWriteValue;
                end
            end else begin
                memDelay <= memDelay - 1;
            end
        end else if ((memReadEnable || memWriteEnable) && !memReadDone && !memWriteDone) begin
            memActive <= 1'b1;
            memDelay <= delays[delayIndex];
            delayIndex <= (delayIndex + 1) % DelayCount;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Errors: data %0d, memory %0d, protocol %0d",
                     dataErrors, memErrors, protocolErrors);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Starts and ends at a falling edge with busy low
    task automatic runRequest(input CacheOp reqKind, input logic [`CACHE_ADDR_WIDTH-1:0] a,
                              input logic [`CACHE_WORD_WIDTH-1:0] d);
        logic [`CACHE_MEM_ADDR_WIDTH-1:0] lineAddr;
        logic [`CACHE_INDEX_WIDTH-1:0] idx;
        logic [`CACHE_TAG_WIDTH-1:0] tag;
        logic [`CACHE_OFFSET_WIDTH-1:0] off;
        logic predictHit;
        logic [`CACHE_LINE_WIDTH-1:0] baseLine;
        logic [`CACHE_LINE_WIDTH-1:0] expLine;
        logic [`CACHE_WORD_WIDTH-1:0] expWord;
        int expReads;
        int expWrites;
        int readsBefore;
        int writesBefore;
        int cycles;
        lineAddr = a[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_WIDTH];
        idx = lineAddr[`CACHE_INDEX_WIDTH-1:0];
        tag = lineAddr[`CACHE_MEM_ADDR_WIDTH-1:`CACHE_INDEX_WIDTH];
        off = a[`CACHE_OFFSET_WIDTH-1:0];
        predictHit = refValid[idx] && (refTag[idx] == tag);
        // A miss refills from memory before anything else happens
        baseLine = predictHit ? refLine[idx] : memLines[lineAddr];
        expWord = baseLine[off * `CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH];
        expLine = baseLine;
        expLine[off * `CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH] = d;
        expReads = (predictHit || (reqKind == CacheOp_Flush)) ? 0 : 1;
        expWrites = (reqKind == CacheOp_Store) ? 1 : 0;
        readsBefore = memReadCount;
        writesBefore = memWriteCount;

        @(posedge clk);
        reqValid <= 1'b1;
        reqOp <= reqKind;
        reqAddr <= a;
        reqData <= d;
        @(posedge clk);
        reqValid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!respDone) begin
            @(negedge clk);
            cycles++;
        end

        assert (memReadCount - readsBefore == expReads) else begin
            memErrors++;
            $display("Mismatch at %0t: memory reads = %0d, expected %0d",
                     $time, memReadCount - readsBefore, expReads);
        end
        if (expReads == 1) begin
            assert (lastReadAddr == lineAddr) else begin
                memErrors++;
                $display("Mismatch at %0t: memAddr = %h, expected %h",
                         $time, lastReadAddr, lineAddr);
            end
        end
        assert (memWriteCount - writesBefore == expWrites) else begin
            memErrors++;
            $display("Mismatch at %0t: memory writes = %0d, expected %0d",
                     $time, memWriteCount - writesBefore, expWrites);
        end
        if (reqKind == CacheOp_Store) begin
            assert (lastWriteAddr == lineAddr && lastWriteLine == expLine) else begin
                memErrors++;
                $display("Mismatch at %0t: memWriteValue = %h at %h, expected %h at %h",
                         $time, lastWriteLine, lastWriteAddr, expLine, lineAddr);
            end
        end
        if (reqKind == CacheOp_Load) begin
            assert (respData == expWord) else begin
                dataErrors++;
                $display("Mismatch at %0t: respData = %h, expected %h", $time, respData, expWord);
            end
        end
        if (reqKind == CacheOp_Load && predictHit) begin
            assert (cycles == 1) else begin
                protocolErrors++;
                $display("Mismatch at %0t: respDone latency = %0d, expected 1", $time, cycles);
            end
        end

        @(negedge clk);
        assert (!busy && !respDone) else begin
            protocolErrors++;
            $display("Error at %0t: cache still busy or responding after respDone", $time);
        end

        if (reqKind == CacheOp_Flush) begin
            refValid[idx] = 1'b0;
        end else begin
            refValid[idx] = 1'b1;
            refTag[idx] = tag;
            refLine[idx] = (reqKind == CacheOp_Store) ? expLine : baseLine;
        end
    endtask

    initial begin
        void'($urandom(32'h00f09f45));
        for (i = 0; i < DelayCount; i++) begin
            delays[i] = 1 + int'($urandom % 4);
        end
        for (i = 0; i < LineCount; i++) begin
            refValid[i] = 1'b0;
        end
        rst <= 1'b1;
        reqValid <= 1'b0;
        reqOp <= CacheOp_Load;
        reqAddr <= '0;
        reqData <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Quiet interface until the first request
        repeat (3) begin
            @(negedge clk);
            assert (!busy && !respDone && !memReadEnable && !memWriteEnable) else begin
                protocolErrors++;
                $display("Error at %0t: cache outputs active after reset", $time);
            end
        end

        // Three tags over four indexes give hits, conflicts and evictions
        for (n = 0; n < RequestCount; n++) begin
            pick = int'($urandom % 20);
            if (pick < 10) begin
                op = CacheOp_Load;
            end else if (pick < 17) begin
                op = CacheOp_Store;
            end else begin
                op = CacheOp_Flush;
            end
            addr = {7'(5 + 40 * ($urandom % 3)), 3'($urandom % 4), 2'($urandom % 4)};
            runRequest(op, addr, $urandom);
        end

        $display("Errors: data %0d, memory %0d, protocol %0d",
                 dataErrors, memErrors, protocolErrors);
        if (dataErrors + memErrors + protocolErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* DCacheTop.sv */
/*
 Top level of the write-through data cache.
 Core requests enter on the req ports, whole lines move on the mem ports.
*/
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module DCacheTop (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    input  CacheTypes::CacheOp reqOp,
    input  logic [`CACHE_ADDR_WIDTH-1:0] reqAddr,
    input  logic [`CACHE_WORD_WIDTH-1:0] reqData,
    output logic busy,
    output logic respDone,
    output logic [`CACHE_WORD_WIDTH-1:0] respData,
    output logic [`CACHE_MEM_ADDR_WIDTH-1:0] memAddr,
    output logic memReadEnable,
    output logic memWriteEnable,
    output logic [`CACHE_LINE_WIDTH-1:0] memWriteValue,
    input  logic memReadDone,
    input  logic memWriteDone,
    input  logic [`CACHE_LINE_WIDTH-1:0] memReadValue
);
    import CacheTypes::*;

    // Controller to replacer
    logic replacerEnable;
    CacheCommand replacerCommand;
    logic [`CACHE_MEM_ADDR_WIDTH-1:0] replacerAddr;
    logic replacerDone;

    // Replacer array request
    logic rplWriteEnable;
    logic [`CACHE_INDEX_WIDTH-1:0] rplIndex;
    logic rplWriteValid;
    logic [`CACHE_TAG_WIDTH-1:0] rplWriteTag;
    logic [`CACHE_LINE_WIDTH-1:0] rplWriteData;

    // Array ports
    logic arrayWriteEnable;
    logic [`CACHE_INDEX_WIDTH-1:0] arrayIndex;
    logic arrayWriteValid;
    logic [`CACHE_TAG_WIDTH-1:0] arrayWriteTag;
    logic [`CACHE_LINE_WIDTH-1:0] arrayWriteData;
    logic arrayReadValid;
    logic [`CACHE_TAG_WIDTH-1:0] arrayReadTag;
    logic [`CACHE_LINE_WIDTH-1:0] arrayReadData;

    DCacheController DCacheController_inst (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqOp(reqOp), .reqAddr(reqAddr), .reqData(reqData),
        .busy(busy), .respDone(respDone), .respData(respData),
        .replacerEnable(replacerEnable), .replacerCommand(replacerCommand),
        .replacerAddr(replacerAddr), .replacerDone(replacerDone),
        .rplWriteEnable(rplWriteEnable), .rplIndex(rplIndex),
        .rplWriteValid(rplWriteValid), .rplWriteTag(rplWriteTag),
        .rplWriteData(rplWriteData),
        .arrayWriteEnable(arrayWriteEnable), .arrayIndex(arrayIndex),
        .arrayWriteValid(arrayWriteValid), .arrayWriteTag(arrayWriteTag),
        .arrayWriteData(arrayWriteData),
        .arrayReadValid(arrayReadValid), .arrayReadTag(arrayReadTag),
        .arrayReadData(arrayReadData)
    );

    DCacheReplacer DCacheReplacer_inst (
        .clk(clk), .rst(rst),
        .enable(replacerEnable), .command(replacerCommand),
        .commandAddr(replacerAddr), .done(replacerDone),
        .arrayWriteEnable(rplWriteEnable), .arrayIndex(rplIndex),
        .arrayWriteValid(rplWriteValid), .arrayWriteTag(rplWriteTag),
        .arrayWriteData(rplWriteData), .arrayReadData(arrayReadData),
        .memAddr(memAddr), .memReadEnable(memReadEnable),
        .memWriteEnable(memWriteEnable), .memWriteValue(memWriteValue),
        .memReadDone(memReadDone), .memWriteDone(memWriteDone),
        .memReadValue(memReadValue)
    );

    DCacheArray DCacheArray_inst (
        .clk(clk), .rst(rst),
        .writeEnable(arrayWriteEnable), .index(arrayIndex),
        .writeValid(arrayWriteValid), .writeTag(arrayWriteTag),
        .writeData(arrayWriteData),
        .readValid(arrayReadValid), .readTag(arrayReadTag), .readData(arrayReadData)
    );

endmodule

`default_nettype wire

/* all.f */
+incdir+.
CacheTypes.sv
DCacheArray.sv
DCacheReplacer.sv
DCacheController.sv
DCacheTop.sv
DCacheChecker.sv
DCacheTb.sv

/* cache_defs.svh */
/*
 Geometry of the direct-mapped data cache, shared by the RTL and the testbench.
 Word i of a line sits at bits [i*CACHE_WORD_WIDTH +: CACHE_WORD_WIDTH].
 A word address splits as {tag, index, offset}, a line address as {tag, index}.
*/
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_WORD_WIDTH 32
`define CACHE_OFFSET_WIDTH 2
// Four words per line
`define CACHE_LINE_WIDTH ((1 << `CACHE_OFFSET_WIDTH) * `CACHE_WORD_WIDTH)
// Eight lines
`define CACHE_INDEX_WIDTH 3
`define CACHE_TAG_WIDTH 7
`define CACHE_MEM_ADDR_WIDTH (`CACHE_TAG_WIDTH + `CACHE_INDEX_WIDTH)
`define CACHE_ADDR_WIDTH (`CACHE_MEM_ADDR_WIDTH + `CACHE_OFFSET_WIDTH)

`endif

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module DCacheTb -f all.f -o DCacheSim

if ! ./obj_dir/DCacheSim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
exit 1
